//--- Makefile
# Verilator build and run of the dual-port L2 memory front end testbench
VERILATOR ?= verilator
TOP       ?= tb_axi_mem_if_dp
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- common/axi_pkg.sv
// AXI-side widths and types for the low-priority port
// Response code and controller FSM state encodings

`default_nettype none

package axi_pkg;

   localparam int unsigned AXI_ADDR_W = 32;
   localparam int unsigned AXI_ID_W   = 4;

   typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic [AXI_ID_W-1:0]   axi_id_t;

   // Only OKAY is ever returned by this slave
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axi_resp_e;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_REQ,
      WR_RESP
   } wr_state_e;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_REQ,
      RD_WAIT,
      RD_RESP
   } rd_state_e;

endpackage

`default_nettype wire

//--- common/bank_req_if.sv
// Request, grant and read-response bundle for one memory access path
// Used between the requesters, the interconnect and the banks

`timescale 1ns/1ps
`default_nettype none

interface bank_req_if;
   import l2_mem_pkg::*;

   logic          req;
   // High means read
   logic          wen;
   l2_word_addr_t addr;
   l2_data_t      wdata;
   l2_be_t        be;
   // Same cycle as req
   logic          gnt;
   // One cycle after the grant
   logic          rvalid;
   l2_data_t      rdata;

   modport requester (output req, wen, addr, wdata, be, input gnt, rvalid, rdata);
   modport arbiter   (input req, wen, addr, wdata, be, output gnt, rvalid, rdata);

   // Bank side, addr carries the row only
   modport memory    (input req, wen, addr, wdata, be, output rvalid, rdata);

endinterface

`default_nettype wire

//--- common/l2_mem_pkg.sv
// Memory-side geometry for the interleaved L2 banks
// Word, byte-enable and address types shared by the interconnect and banks

`default_nettype none

package l2_mem_pkg;

   // Bank geometry
   localparam int unsigned NB_BANKS    = 4;
   localparam int unsigned BANK_SEL_W  = 2;
   localparam int unsigned ROW_W       = 8;
   localparam int unsigned DATA_W      = 64;
   localparam int unsigned NUM_BYTES   = DATA_W / 8;
   localparam int unsigned BYTE_OFF_W  = 3;
   localparam int unsigned WORD_ADDR_W = ROW_W + BANK_SEL_W;

   // Requester slots at the interconnect, HP is the fixed-priority one
   localparam int unsigned NB_REQ    = 3;
   localparam int unsigned REQ_IDX_W = 2;
   localparam logic [REQ_IDX_W-1:0] REQ_WR = 2'd0;
   localparam logic [REQ_IDX_W-1:0] REQ_RD = 2'd1;
   localparam logic [REQ_IDX_W-1:0] REQ_HP = 2'd2;

   typedef logic [DATA_W-1:0]      l2_data_t;
   typedef logic [NUM_BYTES-1:0]   l2_be_t;

   // Low BANK_SEL_W bits pick the bank, the rest is the row
   typedef logic [WORD_ADDR_W-1:0] l2_word_addr_t;
   typedef logic [ROW_W-1:0]       bank_row_t;
   typedef logic [BANK_SEL_W-1:0]  bank_sel_t;

endpackage

`default_nettype wire

//--- flist.f
common/l2_mem_pkg.sv
common/axi_pkg.sv
common/bank_req_if.sv
l2_interco/l2_bank.sv
l2_interco/l2_interco.sv
verilog/axi_write_ctrl.sv
verilog/axi_read_ctrl.sv
verilog/axi_mem_if_dp.sv
testbench/tb_clk_gen.sv
testbench/tb_axi_mem_if_dp.sv

//--- l2_interco/l2_bank.sv
// One L2 memory bank with byte-enabled writes
// Read data is registered and flagged by a one-cycle rvalid pulse

`timescale 1ns/1ps
`default_nettype none

module l2_bank (
   input  logic       clk_i,
   input  logic       arst_n_i,
   bank_req_if.memory port
);
   import l2_mem_pkg::*;

   l2_data_t  mem_q [2**ROW_W];
   bank_row_t row;

   assign row = bank_row_t'(port.addr);

   always_ff @(posedge clk_i) begin
      if (port.req && !port.wen) begin
         for (int i = 0; i < NUM_BYTES; i++) begin
            if (port.be[i]) mem_q[row][i*8 +: 8] <= port.wdata[i*8 +: 8];
         end
      end
      // rdata holds until the next read of this bank
      if (port.req && port.wen) begin
         port.rdata <= mem_q[row];
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         port.rvalid <= 1'b0;
      end else begin
         port.rvalid <= port.req && port.wen;
      end
   end

endmodule

`default_nettype wire

//--- l2_interco/l2_interco.sv
// Per-bank arbiter for the HP, LP write and LP read requesters
// Routes the winner to its bank and returns read data one cycle later

`timescale 1ns/1ps
`default_nettype none

module l2_interco (
   input  logic         clk_i,
   input  logic         arst_n_i,
   bank_req_if.arbiter  hp,
   bank_req_if.arbiter  lp_wr,
   bank_req_if.arbiter  lp_rd,
   bank_req_if          bank [l2_mem_pkg::NB_BANKS]
);
   import l2_mem_pkg::*;

   logic          req_v   [NB_REQ];
   logic          wen_v   [NB_REQ];
   l2_word_addr_t addr_v  [NB_REQ];
   l2_data_t      wdata_v [NB_REQ];
   l2_be_t        be_v    [NB_REQ];

   logic [NB_BANKS-1:0][NB_REQ-1:0] win;
   logic [REQ_IDX_W-1:0]            own [NB_BANKS];
   logic [NB_REQ-1:0]               gnt_v;
   // Low means the LP write wins the next tie on that bank
   logic [NB_BANKS-1:0]             rr_q;
   logic [NB_REQ-1:0]               rd_pend_q;
   bank_sel_t                       rd_sel_q [NB_REQ];
   logic [NB_BANKS-1:0]             bank_rvalid;
   l2_data_t                        bank_rdata [NB_BANKS];

   // Slot order follows REQ_WR, REQ_RD, REQ_HP
   assign req_v   = '{lp_wr.req,   lp_rd.req,   hp.req};
   assign wen_v   = '{lp_wr.wen,   lp_rd.wen,   hp.wen};
   assign addr_v  = '{lp_wr.addr,  lp_rd.addr,  hp.addr};
   assign wdata_v = '{lp_wr.wdata, lp_rd.wdata, hp.wdata};
   assign be_v    = '{lp_wr.be,    lp_rd.be,    hp.be};

   // --------------------------------------------------------------------------
   // Arbitration
   // --------------------------------------------------------------------------
   always_comb begin
      logic [NB_REQ-1:0] hit;
      win   = '0;
      gnt_v = '0;
      for (int b = 0; b < NB_BANKS; b++) begin
         for (int r = 0; r < NB_REQ; r++) begin
            hit[r] = req_v[r] && (addr_v[r][BANK_SEL_W-1:0] == bank_sel_t'(b));
         end
         own[b] = REQ_WR;
         if (hit[REQ_HP]) begin
            win[b][REQ_HP] = 1'b1;
            own[b]         = REQ_HP;
         end else if (hit[REQ_WR] && (!hit[REQ_RD] || !rr_q[b])) begin
            win[b][REQ_WR] = 1'b1;
         end else if (hit[REQ_RD]) begin
            win[b][REQ_RD] = 1'b1;
            own[b]         = REQ_RD;
         end
         gnt_v = gnt_v | win[b];
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rr_q      <= '0;
         rd_pend_q <= '0;
      end else begin
         for (int b = 0; b < NB_BANKS; b++) begin
            if (win[b][REQ_WR]) rr_q[b] <= 1'b1;
            else if (win[b][REQ_RD]) rr_q[b] <= 1'b0;
         end
         for (int r = 0; r < NB_REQ; r++) begin
            rd_pend_q[r] <= gnt_v[r] && wen_v[r];
         end
      end
   end

   // Remember which bank each requester was granted on
   always_ff @(posedge clk_i) begin
      for (int r = 0; r < NB_REQ; r++) begin
         if (gnt_v[r]) rd_sel_q[r] <= addr_v[r][BANK_SEL_W-1:0];
      end
   end

   // --------------------------------------------------------------------------
   // Bank side
   // --------------------------------------------------------------------------
   for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
      assign bank[b].req    = |win[b];
      assign bank[b].wen    = wen_v[own[b]];
      assign bank[b].addr   = addr_v[own[b]] >> BANK_SEL_W;
      assign bank[b].wdata  = wdata_v[own[b]];
      assign bank[b].be     = be_v[own[b]];
      assign bank_rvalid[b] = bank[b].rvalid;
      assign bank_rdata[b]  = bank[b].rdata;

      l2_bank i_l2_bank (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .port     (bank[b])
      );
   end

   // Responses back to the requesters
   assign hp.gnt       = gnt_v[REQ_HP];
   assign lp_wr.gnt    = gnt_v[REQ_WR];
   assign lp_rd.gnt    = gnt_v[REQ_RD];
   assign hp.rvalid    = rd_pend_q[REQ_HP] && bank_rvalid[rd_sel_q[REQ_HP]];
   assign lp_wr.rvalid = rd_pend_q[REQ_WR] && bank_rvalid[rd_sel_q[REQ_WR]];
   assign lp_rd.rvalid = rd_pend_q[REQ_RD] && bank_rvalid[rd_sel_q[REQ_RD]];
   assign hp.rdata     = bank_rdata[rd_sel_q[REQ_HP]];
   assign lp_wr.rdata  = bank_rdata[rd_sel_q[REQ_WR]];
   assign lp_rd.rdata  = bank_rdata[rd_sel_q[REQ_RD]];

endmodule

`default_nettype wire

//--- testbench/tb_axi_mem_if_dp.sv
// Testbench for the dual-port L2 memory front end
// Word-array reference model, response checker, directed and random tests

`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem_if_dp;
   import l2_mem_pkg::*;
   import axi_pkg::*;

   // Fill 1024 + random mix about 1000 + directed tests, doubled with margin
   localparam int unsigned MAX_CYCLES = 6000;
   localparam int unsigned NB_RANDOM  = 200;

   logic clk_i;
   logic arst_n_i;
   logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
   logic ar_valid_i, ar_ready_o, r_valid_o, r_ready_i, r_last_o;
   axi_addr_t     aw_addr_i, ar_addr_i;
   axi_id_t       aw_id_i, ar_id_i, b_id_o, r_id_o;
   l2_data_t      w_data_i, r_data_o, hp_wdata_i, hp_q_o;
   l2_be_t        w_strb_i, hp_be_i;
   axi_resp_e     b_resp_o, r_resp_o;
   logic          hp_cen_i, hp_wen_i;
   l2_word_addr_t hp_addr_i;

   l2_data_t    ref_mem [2**WORD_ADDR_W];
   axi_id_t     exp_b_id_q [$];
   axi_id_t     exp_r_id_q [$];
   l2_data_t    exp_r_data_q [$];
   l2_data_t    exp_hp_q [$];
   string       test_name = "reset";
   int unsigned cycle_cnt = 0;
   logic        hp_rd_q = 1'b0;

   l2_word_addr_t w;
   axi_id_t       held_b_id, held_r_id;
   l2_data_t      held_r_data;
   int unsigned   op;
   logic          seen;

   tb_clk_gen i_tb_clk_gen (.clk_o(clk_i));

   axi_mem_if_dp i_axi_mem_if_dp (.*);

   // -------------------------------------------------------------------------
   // Reference model and failure reporting
   // -------------------------------------------------------------------------
   function automatic l2_data_t ref_merge(input l2_data_t old_word, input l2_data_t new_word,
                                          input l2_be_t strb);
      l2_data_t mask;
      for (int i = 0; i < NUM_BYTES; i++) begin
         mask[8*i +: 8] = {8{strb[i]}};
      end
      return (old_word & ~mask) | (new_word & mask);
   endfunction

   // Odd multiplier keeps every word of the fill distinct
   function automatic l2_data_t fill_word(input l2_word_addr_t addr);
      return l2_data_t'(addr) * 64'h9E37_79B9_7F4A_7C15 + 64'h0123_4567_89AB_CDEF;
   endfunction

   // Random upper bits and byte offset, which the DUT must ignore
   function automatic axi_addr_t to_byte_addr(input l2_word_addr_t addr);
      axi_addr_t a;
      a = axi_addr_t'($urandom);
      a[BYTE_OFF_W +: WORD_ADDR_W] = addr;
      return a;
   endfunction

   task automatic stop_on_error();
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic abort_run(input string msg);
      $display("Error in test %s: %s", test_name, msg);
      stop_on_error();
   endtask

   task automatic check_data(input string what, input l2_data_t exp, input l2_data_t act);
      if (act !== exp) begin
         $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_resp(input string what, input axi_resp_e exp, input axi_resp_e act);
      if (act !== exp) begin
         $display("[FAIL] %s %s expected %s actual %s", test_name, what, exp.name(), act.name());
         stop_on_error();
      end
   endtask

   task automatic check_id(input string what, input axi_id_t exp, input axi_id_t act);
      if (act !== exp) begin
         $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[FAIL] %s %s expected %b actual %b", test_name, what, exp, act);
         stop_on_error();
      end
   endtask

   // -------------------------------------------------------------------------
   // Response checker and timeout
   // -------------------------------------------------------------------------
   always @(posedge clk_i) begin
      hp_rd_q <= arst_n_i && !hp_cen_i && hp_wen_i;
   end

   // Handshakes seen here complete at the next rising edge
   always @(negedge clk_i) begin
      if (arst_n_i && b_valid_o && b_ready_i) begin
         if (exp_b_id_q.size() == 0) abort_run("B response without a pending write");
         else check_id("b_id", exp_b_id_q.pop_front(), b_id_o);
         check_resp("b_resp", OKAY, b_resp_o);
      end
      if (arst_n_i && r_valid_o && r_ready_i) begin
         if (exp_r_id_q.size() == 0) abort_run("R response without a pending read");
         else check_id("r_id", exp_r_id_q.pop_front(), r_id_o);
         check_data("r_data", exp_r_data_q.pop_front(), r_data_o);
         check_resp("r_resp", OKAY, r_resp_o);
         check_flag("r_last", 1'b1, r_last_o);
      end
      if (hp_rd_q) begin
         check_data("hp_q", exp_hp_q.pop_front(), hp_q_o);
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("SOME TESTS FAILED");
         $fatal(1, "Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      end
   end

   // -------------------------------------------------------------------------
   // Stimulus tasks, each starts and ends 1 ns after a rising edge
   // -------------------------------------------------------------------------
   task automatic next_cycle();
      @(posedge clk_i);
      #1;
   endtask

   task automatic issue_write(input l2_word_addr_t addr, input axi_id_t id,
                              input l2_data_t data, input l2_be_t strb);
      aw_valid_i = 1'b1;
      aw_addr_i  = to_byte_addr(addr);
      aw_id_i    = id;
      w_valid_i  = 1'b1;
      w_data_i   = data;
      w_strb_i   = strb;
      ref_mem[addr] = ref_merge(ref_mem[addr], data, strb);
      exp_b_id_q.push_back(id);
      @(negedge clk_i);
      while (!(aw_ready_o && w_ready_o)) @(negedge clk_i);
      next_cycle();
      aw_valid_i = 1'b0;
      w_valid_i  = 1'b0;
   endtask

   task automatic issue_read(input l2_word_addr_t addr, input axi_id_t id);
      ar_valid_i = 1'b1;
      ar_addr_i  = to_byte_addr(addr);
      ar_id_i    = id;
      exp_r_id_q.push_back(id);
      exp_r_data_q.push_back(ref_mem[addr]);
      @(negedge clk_i);
      while (!ar_ready_o) @(negedge clk_i);
      next_cycle();
      ar_valid_i = 1'b0;
   endtask

   task automatic wait_b();
      @(negedge clk_i);
      while (!(b_valid_o && b_ready_i)) @(negedge clk_i);
      next_cycle();
   endtask

   task automatic wait_r();
      @(negedge clk_i);
      while (!(r_valid_o && r_ready_i)) @(negedge clk_i);
      next_cycle();
   endtask

   task automatic hp_write(input l2_word_addr_t addr, input l2_data_t data, input l2_be_t be);
      hp_cen_i   = 1'b0;
      hp_wen_i   = 1'b0;
      hp_addr_i  = addr;
      hp_wdata_i = data;
      hp_be_i    = be;
      ref_mem[addr] = ref_merge(ref_mem[addr], data, be);
      next_cycle();
      hp_cen_i   = 1'b1;
   endtask

   // Checked one cycle later by the response checker
   task automatic hp_read(input l2_word_addr_t addr);
      hp_cen_i  = 1'b0;
      hp_wen_i  = 1'b1;
      hp_addr_i = addr;
      exp_hp_q.push_back(ref_mem[addr]);
      next_cycle();
      hp_cen_i  = 1'b1;
   endtask

   // -------------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------------
   initial begin
      arst_n_i   = 1'b0;
      aw_valid_i = 1'b0;
      aw_addr_i  = '0;
      aw_id_i    = '0;
      w_valid_i  = 1'b0;
      w_data_i   = '0;
      w_strb_i   = '0;
      b_ready_i  = 1'b1;
      ar_valid_i = 1'b0;
      ar_addr_i  = '0;
      ar_id_i    = '0;
      r_ready_i  = 1'b1;
      hp_cen_i   = 1'b1;
      hp_wen_i   = 1'b1;
      hp_addr_i  = '0;
      hp_wdata_i = '0;
      hp_be_i    = '0;
      void'($urandom(82));
      foreach (ref_mem[i]) ref_mem[i] = '0;

      repeat (4) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;
      @(negedge clk_i);
      check_flag("b_valid", 1'b0, b_valid_o);
      check_flag("r_valid", 1'b0, r_valid_o);
      check_flag("aw_ready", 1'b0, aw_ready_o);
      check_flag("w_ready", 1'b0, w_ready_o);
      check_flag("ar_ready", 1'b0, ar_ready_o);
      next_cycle();

      // Defined contents everywhere before any read
      test_name = "fill";
      for (int i = 0; i < 2**WORD_ADDR_W; i++) begin
         hp_write(l2_word_addr_t'(i), fill_word(l2_word_addr_t'(i)), '1);
      end

      test_name = "lp_write_read";
      for (int i = 0; i < 4; i++) begin
         issue_write(l2_word_addr_t'(12 + i), axi_id_t'(i + 1), {$urandom, $urandom}, 8'hA5);
         wait_b();
      end
      for (int i = 0; i < 4; i++) begin
         issue_read(l2_word_addr_t'(12 + i), axi_id_t'(15 - i));
         wait_r();
      end

      test_name = "hp_write_read";
      hp_write(10'h155, {$urandom, $urandom}, 8'h3C);
      hp_read(10'h155);
      hp_write(10'h2B7, {$urandom, $urandom}, 8'hF0);
      issue_read(10'h2B7, 4'h3);
      wait_r();
      issue_write(10'h3C9, 4'hC, {$urandom, $urandom}, 8'h81);
      wait_b();
      hp_read(10'h3C9);

      // Pending LP read on bank 1 while HP keeps that bank busy
      test_name = "hp_priority";
      issue_read(10'h041, 4'h7);
      for (int i = 0; i < 12; i++) begin
         hp_cen_i  = 1'b0;
         hp_wen_i  = 1'b1;
         hp_addr_i = l2_word_addr_t'(int'(10'h045) + 4 * i);
         exp_hp_q.push_back(ref_mem[hp_addr_i]);
         @(negedge clk_i);
         check_flag("r_valid under HP", 1'b0, r_valid_o);
         next_cycle();
      end
      hp_cen_i = 1'b1;
      wait_r();

      // The next word sits on another bank and is not stalled
      test_name = "interleave";
      seen = 1'b0;
      issue_read(10'h042, 4'h8);
      for (int i = 0; i < 8 && !seen; i++) begin
         hp_cen_i  = 1'b0;
         hp_wen_i  = 1'b1;
         hp_addr_i = l2_word_addr_t'(int'(10'h041) + 4 * i);
         exp_hp_q.push_back(ref_mem[hp_addr_i]);
         @(negedge clk_i);
         seen = r_valid_o;
         next_cycle();
      end
      hp_cen_i = 1'b1;
      check_flag("r_valid on other bank", 1'b1, seen);

      test_name = "back_pressure";
      b_ready_i = 1'b0;
      r_ready_i = 1'b0;
      issue_write(10'h0A4, 4'h9, {$urandom, $urandom}, 8'hFF);
      issue_read(10'h0A5, 4'h6);
      @(negedge clk_i);
      while (!(b_valid_o && r_valid_o)) @(negedge clk_i);
      held_b_id   = b_id_o;
      held_r_id   = r_id_o;
      held_r_data = r_data_o;
      next_cycle();
      aw_valid_i = 1'b1;
      w_valid_i  = 1'b1;
      ar_valid_i = 1'b1;
      aw_addr_i  = to_byte_addr(10'h1F0);
      ar_addr_i  = to_byte_addr(10'h1F1);
      repeat (6) begin
         @(negedge clk_i);
         check_flag("b_valid held", 1'b1, b_valid_o);
         check_flag("r_valid held", 1'b1, r_valid_o);
         check_flag("aw_ready", 1'b0, aw_ready_o);
         check_flag("w_ready", 1'b0, w_ready_o);
         check_flag("ar_ready", 1'b0, ar_ready_o);
         check_id("b_id held", held_b_id, b_id_o);
         check_id("r_id held", held_r_id, r_id_o);
         check_data("r_data held", held_r_data, r_data_o);
         next_cycle();
      end
      aw_valid_i = 1'b0;
      w_valid_i  = 1'b0;
      ar_valid_i = 1'b0;
      b_ready_i  = 1'b1;
      r_ready_i  = 1'b1;
      repeat (2) next_cycle();

      test_name = "random_mix";
      for (int i = 0; i < NB_RANDOM; i++) begin
         op = $urandom_range(0, 3);
         w  = l2_word_addr_t'($urandom);
         case (op)
            0: begin
               issue_write(w, axi_id_t'($urandom), {$urandom, $urandom}, l2_be_t'($urandom));
               wait_b();
            end
            1: begin
               issue_read(w, axi_id_t'($urandom));
               wait_r();
            end
            2: hp_write(w, {$urandom, $urandom}, l2_be_t'($urandom));
            default: hp_read(w);
         endcase
      end

      repeat (4) next_cycle();
      if (exp_b_id_q.size() != 0 || exp_r_id_q.size() != 0 || exp_hp_q.size() != 0) begin
         abort_run("responses still outstanding at the end of the run");
      end else begin
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
// Free-running testbench clock

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter real PERIOD_NS = 10.0
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

//--- verilog/axi_mem_if_dp.sv
// Dual-port L2 memory front end top level
// LP AXI-style port and HP SRAM-style port onto four interleaved banks

`timescale 1ns/1ps
`default_nettype none

module axi_mem_if_dp (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   // Low-priority write address, data and response
   input  logic                      aw_valid_i,
   output logic                      aw_ready_o,
   input  axi_pkg::axi_addr_t        aw_addr_i,
   input  axi_pkg::axi_id_t          aw_id_i,
   input  logic                      w_valid_i,
   output logic                      w_ready_o,
   input  l2_mem_pkg::l2_data_t      w_data_i,
   input  l2_mem_pkg::l2_be_t        w_strb_i,
   output logic                      b_valid_o,
   input  logic                      b_ready_i,
   output axi_pkg::axi_id_t          b_id_o,
   output axi_pkg::axi_resp_e        b_resp_o,
   // Low-priority read address and data
   input  logic                      ar_valid_i,
   output logic                      ar_ready_o,
   input  axi_pkg::axi_addr_t        ar_addr_i,
   input  axi_pkg::axi_id_t          ar_id_i,
   output logic                      r_valid_o,
   input  logic                      r_ready_i,
   output axi_pkg::axi_id_t          r_id_o,
   output l2_mem_pkg::l2_data_t      r_data_o,
   output axi_pkg::axi_resp_e        r_resp_o,
   output logic                      r_last_o,
   // High-priority SRAM-style port, never stalled
   input  logic                      hp_cen_i,
   input  logic                      hp_wen_i,
   input  l2_mem_pkg::l2_word_addr_t hp_addr_i,
   input  l2_mem_pkg::l2_data_t      hp_wdata_i,
   input  l2_mem_pkg::l2_be_t        hp_be_i,
   output l2_mem_pkg::l2_data_t      hp_q_o
);
   import l2_mem_pkg::*;

   bank_req_if hp_bus ();
   bank_req_if wr_bus ();
   bank_req_if rd_bus ();
   bank_req_if bank_bus [NB_BANKS] ();

   // ---------------------------------------------------------------------------
   // HP port onto the request bundle
   // ---------------------------------------------------------------------------
   assign hp_bus.req   = ~hp_cen_i;
   assign hp_bus.wen   = hp_wen_i;
   assign hp_bus.addr  = hp_addr_i;
   assign hp_bus.wdata = hp_wdata_i;
   assign hp_bus.be    = hp_be_i;
   assign hp_q_o       = hp_bus.rdata;

   axi_write_ctrl i_axi_write_ctrl (
      .clk_i, .arst_n_i,
      .aw_valid_i, .aw_ready_o, .aw_addr_i, .aw_id_i,
      .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i,
      .b_valid_o, .b_ready_i, .b_id_o, .b_resp_o,
      .mem (wr_bus)
   );

   axi_read_ctrl i_axi_read_ctrl (
      .clk_i, .arst_n_i,
      .ar_valid_i, .ar_ready_o, .ar_addr_i, .ar_id_i,
      .r_valid_o, .r_ready_i, .r_id_o, .r_data_o, .r_resp_o, .r_last_o,
      .mem (rd_bus)
   );

   l2_interco i_l2_interco (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .hp       (hp_bus),
      .lp_wr    (wr_bus),
      .lp_rd    (rd_bus),
      .bank     (bank_bus)
   );

endmodule

`default_nettype wire

//--- verilog/axi_read_ctrl.sv
// Low-priority single-beat read controller
// Issues one bank read per AR and holds the R beat until it is taken

`timescale 1ns/1ps
`default_nettype none

module axi_read_ctrl (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  logic                 ar_valid_i,
   output logic                 ar_ready_o,
   input  axi_pkg::axi_addr_t   ar_addr_i,
   input  axi_pkg::axi_id_t     ar_id_i,
   output logic                 r_valid_o,
   input  logic                 r_ready_i,
   output axi_pkg::axi_id_t     r_id_o,
   output l2_mem_pkg::l2_data_t r_data_o,
   output axi_pkg::axi_resp_e   r_resp_o,
   output logic                 r_last_o,
   bank_req_if.requester        mem
);
   import axi_pkg::*;
   import l2_mem_pkg::*;

   rd_state_e     state_q, state_d;
   logic          accept;
   axi_id_t       id_q;
   l2_word_addr_t addr_q;
   l2_data_t      data_q;

   assign accept     = (state_q == RD_IDLE) && ar_valid_i;
   assign ar_ready_o = accept;

   always_comb begin
      state_d = state_q;
      case (state_q)
         RD_IDLE: if (accept)     state_d = RD_REQ;
         RD_REQ:  if (mem.gnt)    state_d = RD_WAIT;
         RD_WAIT: if (mem.rvalid) state_d = RD_RESP;
         RD_RESP: if (r_ready_i)  state_d = RD_IDLE;
         default:                 state_d = RD_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= RD_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         id_q   <= ar_id_i;
         addr_q <= ar_addr_i[BYTE_OFF_W +: WORD_ADDR_W];
      end
      // Captured once, so R stays stable under back-pressure
      if ((state_q == RD_WAIT) && mem.rvalid) begin
         data_q <= mem.rdata;
      end
   end

   assign mem.req   = (state_q == RD_REQ);
   assign mem.wen   = 1'b1;
   assign mem.addr  = addr_q;
   assign mem.wdata = '0;
   assign mem.be    = '0;

   assign r_valid_o = (state_q == RD_RESP);
   assign r_id_o    = id_q;
   assign r_data_o  = data_q;
   assign r_resp_o  = OKAY;
   // Single beat per transaction
   assign r_last_o  = 1'b1;

endmodule

`default_nettype wire

//--- verilog/axi_write_ctrl.sv
// Low-priority single-beat write controller
// Takes AW and W together, issues one bank write, returns the B response

`timescale 1ns/1ps
`default_nettype none

module axi_write_ctrl (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  logic                 aw_valid_i,
   output logic                 aw_ready_o,
   input  axi_pkg::axi_addr_t   aw_addr_i,
   input  axi_pkg::axi_id_t     aw_id_i,
   input  logic                 w_valid_i,
   output logic                 w_ready_o,
   input  l2_mem_pkg::l2_data_t w_data_i,
   input  l2_mem_pkg::l2_be_t   w_strb_i,
   output logic                 b_valid_o,
   input  logic                 b_ready_i,
   output axi_pkg::axi_id_t     b_id_o,
   output axi_pkg::axi_resp_e   b_resp_o,
   bank_req_if.requester        mem
);
   import axi_pkg::*;
   import l2_mem_pkg::*;

   wr_state_e     state_q, state_d;
   logic          accept;
   axi_id_t       id_q;
   l2_word_addr_t addr_q;
   l2_data_t      data_q;
   l2_be_t        strb_q;

   // Address and data are taken in the same cycle
   assign accept     = (state_q == WR_IDLE) && aw_valid_i && w_valid_i;
   assign aw_ready_o = accept;
   assign w_ready_o  = accept;

   always_comb begin
      state_d = state_q;
      case (state_q)
         WR_IDLE: if (accept)    state_d = WR_REQ;
         WR_REQ:  if (mem.gnt)   state_d = WR_RESP;
         WR_RESP: if (b_ready_i) state_d = WR_IDLE;
         default:                state_d = WR_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= WR_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Drop the byte offset, keep only the word address bits
   always_ff @(posedge clk_i) begin
      if (accept) begin
         id_q   <= aw_id_i;
         addr_q <= aw_addr_i[BYTE_OFF_W +: WORD_ADDR_W];
         data_q <= w_data_i;
         strb_q <= w_strb_i;
      end
   end

   assign mem.req   = (state_q == WR_REQ);
   assign mem.wen   = 1'b0;
   assign mem.addr  = addr_q;
   assign mem.wdata = data_q;
   assign mem.be    = strb_q;

   assign b_valid_o = (state_q == WR_RESP);
   assign b_id_o    = id_q;
   assign b_resp_o  = OKAY;

endmodule

`default_nettype wire
